//--- hdl/conv_settings.svh
`ifndef CONV_SETTINGS_SVH
`define CONV_SETTINGS_SVH

// window geometry
`define CONV_TAPS 9
`define CONV_KSIZE 3

// bus and data widths
`define CONV_ADDR_W 32
`define CONV_DATA_W 8
`define CONV_CODE_W 2

// bits 12:5 of a tap sum are kept
`define CONV_ACC_SHIFT 5

// shape limits
`define CONV_MAX_DIM 16
`define CONV_DIM_W 5

`endif

//--- hdl/conv_pkg.sv
`default_nettype none

`include "conv_settings.svh"

package conv_pkg;

  typedef logic [`CONV_ADDR_W-1:0] addr_t;
  typedef logic [`CONV_DIM_W-1:0] dim_t;
  typedef logic signed [`CONV_DATA_W-1:0] pixel_t;

  // nine 2-bit codes into a four-byte codebook
  typedef logic [`CONV_TAPS*`CONV_CODE_W-1:0] weight_word_t;
  typedef logic [(1 << `CONV_CODE_W)*`CONV_DATA_W-1:0] codebook_t;

  typedef pixel_t [`CONV_TAPS-1:0] tap_array_t;

  // nine 16-bit products need four more bits
  typedef logic signed [2*`CONV_DATA_W+3:0] sum_t;

  typedef struct packed {
    addr_t addr;
    logic  first_channel;
  } pixel_tag_t;

  typedef enum logic [2:0] {
    SEQ_IDLE,
    SEQ_LOAD_SHAPE,
    SEQ_LOAD_COEF,
    SEQ_WINDOW,
    SEQ_DRAIN,
    SEQ_DONE
  } seq_state_t;

endpackage

`default_nettype wire

//--- hdl/conv_ifs.sv
`default_nettype none

// shape and coefficient loads
interface conv_fetch_if;
  import conv_pkg::*;

  logic load_shape;
  logic load_coef;
  dim_t kernel;
  dim_t channel;
  logic done;

  modport sequencer (output load_shape, load_coef, kernel, channel, input done);
  modport fetcher (input load_shape, load_coef, kernel, channel, output done);
endinterface

// one window request per pixel
interface conv_window_if;
  import conv_pkg::*;

  logic       req;
  dim_t       channel;
  dim_t       row;
  dim_t       col;
  pixel_tag_t tag;
  logic       done;

  modport sequencer (output req, channel, row, col, tag, input done);
  modport fetcher (input req, channel, row, col, tag, output done);
endinterface

// pixel pipeline link, no back-pressure
interface conv_pixel_if #(
  parameter int DATA_W = $bits(conv_pkg::sum_t)
);
  import conv_pkg::*;

  logic              valid;
  logic [DATA_W-1:0] data;
  pixel_tag_t        tag;

  modport producer (output valid, data, tag);
  modport consumer (input valid, data, tag);
endinterface

`default_nettype wire

//--- hdl/conv_sequencer.sv
`default_nettype none

module conv_sequencer (
  input  logic             clk,
  input  logic             rst,
  input  logic             start,
  output logic             finish,
  conv_fetch_if.sequencer  fetch,
  conv_window_if.sequencer win,
  input  conv_pkg::dim_t   rows,
  input  conv_pkg::dim_t   channels,
  input  conv_pkg::dim_t   kernels,
  input  logic             writer_busy,
  input  logic             mac_busy
);
  import conv_pkg::*;

  seq_state_t state;
  dim_t       kernel;
  dim_t       channel;
  dim_t       row;
  dim_t       col;
  logic       pending;
  logic       last_col;
  logic       last_row;
  logic       last_chan;
  addr_t      plane;
  pixel_tag_t tag;

  assign last_col  = (col == rows - 1'b1);
  assign last_row  = (row == rows - 1'b1);
  assign last_chan = (channel == channels - 1'b1);

  // output plane of the current kernel
  assign plane        = addr_t'(rows) * addr_t'(rows);
  assign tag.addr     = addr_t'(kernel) * plane + addr_t'(row) * addr_t'(rows) + addr_t'(col);
  assign tag.first_channel = (channel == '0);

  assign fetch.kernel  = kernel;
  assign fetch.channel = channel;

  assign win.req     = (state == SEQ_WINDOW) && !pending;
  assign win.channel = channel;
  assign win.row     = row;
  assign win.col     = col;
  assign win.tag     = tag;

  assign finish = (state == SEQ_DONE);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state            <= SEQ_IDLE;
      fetch.load_shape <= 1'b0;
      fetch.load_coef  <= 1'b0;
      pending          <= 1'b0;
      kernel           <= '0;
      channel          <= '0;
      row              <= '0;
      col              <= '0;
    end else begin
      fetch.load_shape <= 1'b0;
      fetch.load_coef  <= 1'b0;
      case (state)
        SEQ_IDLE: begin
          if (start) begin
            fetch.load_shape <= 1'b1;
            kernel           <= '0;
            channel          <= '0;
            row              <= '0;
            col              <= '0;
            state            <= SEQ_LOAD_SHAPE;
          end
        end
        SEQ_LOAD_SHAPE: begin
          if (fetch.done) state <= SEQ_DRAIN;
        end
        // coefficients only change with mac and writer empty
        SEQ_DRAIN: begin
          if (!mac_busy && !writer_busy) begin
            if (kernel == kernels) begin
              state <= SEQ_DONE;
            end else begin
              fetch.load_coef <= 1'b1;
              state           <= SEQ_LOAD_COEF;
            end
          end
        end
        SEQ_LOAD_COEF: begin
          if (fetch.done) state <= SEQ_WINDOW;
        end
        SEQ_WINDOW: begin
          if (win.req) pending <= 1'b1;
          if (win.done) begin
            pending <= 1'b0;
            if (!last_col) begin
              col <= col + 1'b1;
            end else begin
              col <= '0;
              if (!last_row) begin
                row <= row + 1'b1;
              end else begin
                row   <= '0;
                state <= SEQ_DRAIN;
                if (!last_chan) begin
                  channel <= channel + 1'b1;
                end else begin
                  channel <= '0;
                  kernel  <= kernel + 1'b1;
                end
              end
            end
          end
        end
        default: state <= SEQ_IDLE;
      endcase
    end
  end

  // one request outstanding per link
  assert property (@(posedge clk) disable iff (rst)
    win.req |=> !win.req until_with win.done);

  assert property (@(posedge clk) disable iff (rst)
    (fetch.load_shape || fetch.load_coef) |=>
      !(fetch.load_shape || fetch.load_coef) until_with fetch.done);

endmodule

`default_nettype wire

//--- hdl/conv_coef_fetch.sv
`default_nettype none

`include "conv_settings.svh"

module conv_coef_fetch (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   start,
  input  conv_pkg::codebook_t    w8,
  conv_fetch_if.fetcher          fetch,
  output logic                   param_en,
  output conv_pkg::addr_t        param_addr,
  input  logic [31:0]            param_rdata,
  output logic                   bias_en,
  output conv_pkg::addr_t        bias_addr,
  input  logic [31:0]            bias_rdata,
  output logic                   weight_en,
  output conv_pkg::addr_t        weight_addr,
  input  conv_pkg::weight_word_t weight_rdata,
  output conv_pkg::dim_t         rows,
  output conv_pkg::dim_t         channels,
  output conv_pkg::dim_t         kernels,
  output conv_pkg::pixel_t       bias_slice,
  output conv_pkg::tap_array_t   weights
);
  import conv_pkg::*;

  codebook_t  codebook;
  logic [3:0] shape_pipe;
  logic [2:0] coef_pipe;

  // words 0..2 read on the three cycles after load_shape
  assign param_en   = |shape_pipe[2:0];
  assign param_addr = shape_pipe[2] ? addr_t'(2) : shape_pipe[1] ? addr_t'(1) : addr_t'(0);

  assign bias_en     = coef_pipe[0];
  assign weight_en   = coef_pipe[0];
  assign bias_addr   = addr_t'(fetch.kernel);
  assign weight_addr = addr_t'(fetch.kernel) * addr_t'(channels) + addr_t'(fetch.channel);

  assign fetch.done = shape_pipe[3] | coef_pipe[2];

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      shape_pipe <= '0;
      coef_pipe  <= '0;
      rows       <= '0;
      channels   <= '0;
      kernels    <= '0;
    end else begin
      shape_pipe <= {shape_pipe[2:0], fetch.load_shape};
      coef_pipe  <= {coef_pipe[1:0], fetch.load_coef};
      if (shape_pipe[1]) rows <= dim_t'(param_rdata);
      if (shape_pipe[2]) channels <= dim_t'(param_rdata);
      if (shape_pipe[3]) kernels <= dim_t'(param_rdata);
    end
  end

  always_ff @(posedge clk) begin
    if (start) codebook <= w8;
    if (coef_pipe[1]) begin
      bias_slice <= bias_rdata[`CONV_ACC_SHIFT +: `CONV_DATA_W];
      // code 0 picks the low byte
      for (int t = 0; t < `CONV_TAPS; t++) begin
        weights[t] <= codebook[weight_rdata[t*`CONV_CODE_W +: `CONV_CODE_W]*`CONV_DATA_W
                               +: `CONV_DATA_W];
      end
    end
  end

  // shape word from memory must fit the counters
  assert property (@(posedge clk) disable iff (rst)
    shape_pipe[3] |-> (rows >= 3) && (rows <= `CONV_MAX_DIM));

endmodule

`default_nettype wire

//--- hdl/conv_window_fetch.sv
`default_nettype none

`include "conv_settings.svh"

module conv_window_fetch (
  input  logic            clk,
  input  logic            rst,
  conv_window_if.fetcher  win,
  input  conv_pkg::dim_t  rows,
  output logic            input_en,
  output conv_pkg::addr_t input_addr,
  input  logic [7:0]      input_rdata,
  conv_pixel_if.producer  taps
);
  import conv_pkg::*;

  dim_t       row_q;
  dim_t       col_q;
  dim_t       chan_q;
  pixel_tag_t tag_q;
  logic       active;
  logic [3:0] step;
  dim_t       cur_row;
  dim_t       cur_col;
  dim_t       cur_chan;
  logic [3:0] cur_step;
  logic       issue;
  logic [5:0] ty;
  logic [5:0] tx;
  addr_t      plane;
  addr_t      plane_base;
  logic       cap_valid;
  logic       cap_hit;
  logic [3:0] cap_idx;
  logic       out_valid;
  tap_array_t tap_q;

  // tap 0 is read in the request cycle
  assign issue    = win.req | active;
  assign cur_row  = win.req ? win.row : row_q;
  assign cur_col  = win.req ? win.col : col_q;
  assign cur_chan = win.req ? win.channel : chan_q;
  assign cur_step = win.req ? 4'd0 : step;

  // padded coordinates, one above the image ones
  assign ty = 6'(cur_row) + 6'(cur_step / `CONV_KSIZE);
  assign tx = 6'(cur_col) + 6'(cur_step % `CONV_KSIZE);

  assign plane      = addr_t'(rows) * addr_t'(rows);
  assign plane_base = addr_t'(cur_chan) * plane;

  assign input_en = issue && (ty != '0) && (ty <= 6'(rows)) && (tx != '0) && (tx <= 6'(rows));
  assign input_addr = plane_base + addr_t'(ty - 6'd1) * addr_t'(rows) + addr_t'(tx - 6'd1);

  assign win.done   = out_valid;
  assign taps.valid = out_valid;
  assign taps.data  = tap_q;
  assign taps.tag   = tag_q;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      active    <= 1'b0;
      step      <= '0;
      cap_valid <= 1'b0;
      out_valid <= 1'b0;
    end else begin
      cap_valid <= issue;
      out_valid <= cap_valid && (cap_idx == 4'(`CONV_TAPS - 1));
      if (win.req) begin
        active <= 1'b1;
        step   <= 4'd1;
      end else if (active) begin
        step <= step + 1'b1;
        if (step == 4'(`CONV_TAPS - 1)) active <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    cap_idx <= cur_step;
    cap_hit <= input_en;
    if (win.req) begin
      row_q  <= win.row;
      col_q  <= win.col;
      chan_q <= win.channel;
      tag_q  <= win.tag;
    end
    // padding taps read as zero
    if (cap_valid) tap_q[cap_idx] <= cap_hit ? input_rdata : '0;
  end

  // reads belong to a window centred inside the image
  assert property (@(posedge clk) disable iff (rst)
    input_en |-> (cur_row < rows) && (cur_col < rows) && (input_addr < plane_base + plane));

endmodule

`default_nettype wire

//--- hdl/conv_mac.sv
`default_nettype none

`include "conv_settings.svh"

module conv_mac (
  input  logic                 clk,
  input  logic                 rst,
  input  conv_pkg::tap_array_t weights,
  conv_pixel_if.consumer       taps,
  conv_pixel_if.producer       sum,
  output logic                 busy
);
  import conv_pkg::*;

  tap_array_t                       tap_in;
  logic signed [2*`CONV_DATA_W-1:0] prod [`CONV_TAPS];
  sum_t                             acc;
  sum_t                             sum_q;
  pixel_tag_t                       tag1;
  pixel_tag_t                       tag2;
  logic                             s1_valid;
  logic                             s2_valid;

  assign tap_in = taps.data;

  // adder tree over the registered products
  always_comb begin
    acc = '0;
    for (int t = 0; t < `CONV_TAPS; t++) begin
      acc = acc + sum_t'(prod[t]);
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
    end else begin
      s1_valid <= taps.valid;
      s2_valid <= s1_valid;
    end
  end

  always_ff @(posedge clk) begin
    for (int t = 0; t < `CONV_TAPS; t++) begin
      prod[t] <= $signed(tap_in[t]) * $signed(weights[t]);
    end
    tag1  <= taps.tag;
    sum_q <= acc;
    tag2  <= tag1;
  end

  assign sum.valid = s2_valid;
  assign sum.data  = sum_q;
  assign sum.tag   = tag2;
  assign busy      = s1_valid | s2_valid;

endmodule

`default_nettype wire

//--- hdl/conv_output_writer.sv
`default_nettype none

`include "conv_settings.svh"

module conv_output_writer (
  input  logic             clk,
  input  logic             rst,
  conv_pixel_if.consumer   sum,
  input  conv_pkg::pixel_t bias_slice,
  output logic             output_en,
  output conv_pkg::addr_t  output_addr,
  input  logic [7:0]       output_rdata,
  output logic             output_we,
  output conv_pkg::pixel_t output_wdata,
  output logic             busy
);
  import conv_pkg::*;

  sum_t   sum_in;
  pixel_t slice_q;
  logic   first_q;

  assign sum_in = sum.data;

  // read in the cycle after the sum, write one cycle later
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      output_en <= 1'b0;
      output_we <= 1'b0;
    end else begin
      output_en <= sum.valid;
      output_we <= output_en;
    end
  end

  always_ff @(posedge clk) begin
    if (sum.valid) begin
      output_addr <= sum.tag.addr;
      first_q     <= sum.tag.first_channel;
      slice_q     <= sum_in[`CONV_ACC_SHIFT +: `CONV_DATA_W];
    end
  end

  // old byte arrives on rdata in the write cycle, sums wrap at 8 bits
  assign output_wdata = first_q ? bias_slice + slice_q : pixel_t'(output_rdata) + slice_q;
  assign busy         = output_en | output_we;

  // pixels reach the writer at least a window apart
  assert property (@(posedge clk) disable iff (rst) output_we |=> !output_we);

endmodule

`default_nettype wire

//--- hdl/conv_top.sv
`default_nettype none

module conv_top (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   start,
  input  conv_pkg::codebook_t    w8,
  output logic                   param_en,
  output conv_pkg::addr_t        param_addr,
  input  logic [31:0]            param_rdata,
  output logic                   bias_en,
  output conv_pkg::addr_t        bias_addr,
  input  logic [31:0]            bias_rdata,
  output logic                   weight_en,
  output conv_pkg::addr_t        weight_addr,
  input  conv_pkg::weight_word_t weight_rdata,
  output logic                   input_en,
  output conv_pkg::addr_t        input_addr,
  input  logic [7:0]             input_rdata,
  output logic                   output_en,
  output conv_pkg::addr_t        output_addr,
  input  logic [7:0]             output_rdata,
  output logic                   output_we,
  output logic [7:0]             output_wdata,
  output logic                   finish
);
  import conv_pkg::*;

  dim_t       rows;
  dim_t       channels;
  dim_t       kernels;
  pixel_t     bias_slice;
  tap_array_t weights;
  logic       mac_busy;
  logic       writer_busy;

  conv_fetch_if fetch_link ();
  conv_window_if win_link ();
  conv_pixel_if #(.DATA_W($bits(tap_array_t))) tap_link ();
  conv_pixel_if #(.DATA_W($bits(sum_t))) sum_link ();

  conv_sequencer i_sequencer (
    .clk         (clk),
    .rst         (rst),
    .start       (start),
    .finish      (finish),
    .fetch       (fetch_link),
    .win         (win_link),
    .rows        (rows),
    .channels    (channels),
    .kernels     (kernels),
    .writer_busy (writer_busy),
    .mac_busy    (mac_busy)
  );

  conv_coef_fetch i_coef_fetch (
    .clk          (clk),
    .rst          (rst),
    .start        (start),
    .w8           (w8),
    .fetch        (fetch_link),
    .param_en     (param_en),
    .param_addr   (param_addr),
    .param_rdata  (param_rdata),
    .bias_en      (bias_en),
    .bias_addr    (bias_addr),
    .bias_rdata   (bias_rdata),
    .weight_en    (weight_en),
    .weight_addr  (weight_addr),
    .weight_rdata (weight_rdata),
    .rows         (rows),
    .channels     (channels),
    .kernels      (kernels),
    .bias_slice   (bias_slice),
    .weights      (weights)
  );

  conv_window_fetch i_window_fetch (
    .clk         (clk),
    .rst         (rst),
    .win         (win_link),
    .rows        (rows),
    .input_en    (input_en),
    .input_addr  (input_addr),
    .input_rdata (input_rdata),
    .taps        (tap_link)
  );

  conv_mac i_mac (
    .clk     (clk),
    .rst     (rst),
    .weights (weights),
    .taps    (tap_link),
    .sum     (sum_link),
    .busy    (mac_busy)
  );

  conv_output_writer i_output_writer (
    .clk          (clk),
    .rst          (rst),
    .sum          (sum_link),
    .bias_slice   (bias_slice),
    .output_en    (output_en),
    .output_addr  (output_addr),
    .output_rdata (output_rdata),
    .output_we    (output_we),
    .output_wdata (output_wdata),
    .busy         (writer_busy)
  );

endmodule

`default_nettype wire

//--- testbench/conv_tb.sv
`default_nettype none

`include "conv_settings.svh"

module conv_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import conv_pkg::*;

  localparam int RUNS      = 3;
  localparam int MEM_DEPTH = 1024;

  logic         clk;
  logic         rst;
  logic         start;
  codebook_t    w8;
  logic         param_en;
  addr_t        param_addr;
  logic [31:0]  param_rdata;
  logic         bias_en;
  addr_t        bias_addr;
  logic [31:0]  bias_rdata;
  logic         weight_en;
  addr_t        weight_addr;
  weight_word_t weight_rdata;
  logic         input_en;
  addr_t        input_addr;
  logic [7:0]   input_rdata;
  logic         output_en;
  addr_t        output_addr;
  logic [7:0]   output_rdata;
  logic         output_we;
  logic [7:0]   output_wdata;
  logic         finish;

  logic [31:0]  param_mem [0:3];
  logic [31:0]  bias_mem [0:15];
  weight_word_t weight_mem [0:255];
  logic [7:0]   input_mem [0:MEM_DEPTH-1];
  logic [7:0]   output_mem [0:MEM_DEPTH-1];
  pixel_t       expected [0:MEM_DEPTH-1];
  dim_t         write_cnt [0:MEM_DEPTH-1];

  int   seed;
  int   cycle_count;
  int   cycle_limit;
  int   run_rows [RUNS];
  int   run_channels [RUNS];
  int   run_kernels [RUNS];
  int   shape_rows;
  int   shape_channels;
  int   shape_kernels;
  int   param_idx;
  int   coef_idx;
  int   finish_count;
  logic quiet;

  // requests seen in the cycle before the read edge
  logic       param_req;
  addr_t      param_req_addr;
  logic       bias_req;
  addr_t      bias_req_addr;
  logic       weight_req;
  addr_t      weight_req_addr;
  logic       input_req;
  addr_t      input_req_addr;
  logic       output_req;
  addr_t      output_req_addr;
  logic       write_req;
  addr_t      write_req_addr;
  logic [7:0] write_req_data;

  conv_top i_dut (
    .clk          (clk),
    .rst          (rst),
    .start        (start),
    .w8           (w8),
    .param_en     (param_en),
    .param_addr   (param_addr),
    .param_rdata  (param_rdata),
    .bias_en      (bias_en),
    .bias_addr    (bias_addr),
    .bias_rdata   (bias_rdata),
    .weight_en    (weight_en),
    .weight_addr  (weight_addr),
    .weight_rdata (weight_rdata),
    .input_en     (input_en),
    .input_addr   (input_addr),
    .input_rdata  (input_rdata),
    .output_en    (output_en),
    .output_addr  (output_addr),
    .output_rdata (output_rdata),
    .output_we    (output_we),
    .output_wdata (output_wdata),
    .finish       (finish)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Simulation FAILED");
    $fatal(1);
  endtask

  task automatic check_byte(input string name, input pixel_t got, input pixel_t exp);
    if (got !== exp)
      report_failure($sformatf("ERR %s got 0x%h expected 0x%h", name, got, exp));
  endtask

  task automatic check_count(input string name, input dim_t got, input dim_t exp);
    if (got !== exp)
      report_failure($sformatf("ERR %s got 0x%h expected 0x%h", name, got, exp));
  endtask

  task automatic check_addr(input string name, input addr_t got, input addr_t exp);
    if (got !== exp)
      report_failure($sformatf("ERR %s got 0x%h expected 0x%h", name, got, exp));
  endtask

  task automatic verify_in_range(input string name, input addr_t addr, input int limit);
    if (addr >= addr_t'(limit))
      report_failure($sformatf("%s 0x%h lies outside its region of %0d words",
                               name, addr, limit));
  endtask

  function automatic int pick_in_range(input int lo, input int hi);
    int r;
    r = $random(seed);
    return lo + int'($unsigned(r) % (hi - lo + 1));
  endfunction

  // codebook byte picked by the 2-bit code of tap t
  function automatic pixel_t tap_weight(input codebook_t book, input weight_word_t word,
                                        input int t);
    logic [`CONV_CODE_W-1:0] code;
    code = word[t*`CONV_CODE_W +: `CONV_CODE_W];
    return book[int'(code)*`CONV_DATA_W +: `CONV_DATA_W];
  endfunction

  task automatic fill_memories();
    int i;
    param_mem[0] = shape_rows;
    param_mem[1] = shape_channels;
    param_mem[2] = shape_kernels;
    param_mem[3] = $random(seed);
    for (i = 0; i < 16; i++) begin
      bias_mem[i] = $random(seed);
    end
    for (i = 0; i < 256; i++) begin
      weight_mem[i] = weight_word_t'($random(seed));
    end
    // old output bytes are random, the first channel must overwrite them
    for (i = 0; i < MEM_DEPTH; i++) begin
      input_mem[i]  = 8'($random(seed));
      output_mem[i] = 8'($random(seed));
      write_cnt[i]  = '0;
    end
    w8 = $random(seed);
  endtask

  task automatic compute_expected();
    int          k;
    int          c;
    int          r;
    int          x;
    int          t;
    int          ty;
    int          tx;
    int          a;
    int          plane;
    int          acc;
    logic [31:0] acc_bits;
    pixel_t      pix;
    pixel_t      slice;
    pixel_t      bias_part;
    plane = shape_rows * shape_rows;
    for (k = 0; k < shape_kernels; k++) begin
      bias_part = bias_mem[k][`CONV_ACC_SHIFT +: `CONV_DATA_W];
      for (c = 0; c < shape_channels; c++) begin
        for (r = 0; r < shape_rows; r++) begin
          for (x = 0; x < shape_rows; x++) begin
            acc = 0;
            for (t = 0; t < `CONV_TAPS; t++) begin
              ty = r + t / `CONV_KSIZE - 1;
              tx = x + t % `CONV_KSIZE - 1;
              // zero padding outside the image
              if (ty >= 0 && ty < shape_rows && tx >= 0 && tx < shape_rows) begin
                pix = input_mem[c * plane + ty * shape_rows + tx];
                acc += pix * tap_weight(w8, weight_mem[k * shape_channels + c], t);
              end
            end
            acc_bits = acc;
            slice = acc_bits[`CONV_ACC_SHIFT +: `CONV_DATA_W];
            a = k * plane + r * shape_rows + x;
            if (c == 0) begin
              expected[a] = bias_part + slice;
            end else begin
              expected[a] = expected[a] + slice;
            end
          end
        end
      end
    end
  endtask

  task automatic run_conv(input int run);
    int a;
    int plane;
    shape_rows     = run_rows[run];
    shape_channels = run_channels[run];
    shape_kernels  = run_kernels[run];
    plane          = shape_rows * shape_rows;
    @(posedge clk);
    #1;
    fill_memories();
    compute_expected();
    param_idx = 0;
    coef_idx  = 0;
    quiet     = 1'b0;
    start     = 1'b1;
    @(posedge clk);
    #1;
    start = 1'b0;
    wait (finish_count > run);
    // bus must stay silent after finish
    repeat (10) @(posedge clk);
    check_count("param reads", dim_t'(param_idx), dim_t'(3));
    check_count("coef loads", dim_t'(coef_idx), dim_t'(shape_kernels * shape_channels));
    for (a = 0; a < shape_kernels * plane; a++) begin
      check_byte($sformatf("output_mem[0x%h]", a), pixel_t'(output_mem[a]), expected[a]);
      check_count($sformatf("write count[0x%h]", a), write_cnt[a], dim_t'(shape_channels));
    end
  endtask

  // synchronous memories with one cycle of read latency
  always begin : memory_model
    @(negedge clk);
    param_req       = param_en;
    param_req_addr  = param_addr;
    bias_req        = bias_en;
    bias_req_addr   = bias_addr;
    weight_req      = weight_en;
    weight_req_addr = weight_addr;
    input_req       = input_en;
    input_req_addr  = input_addr;
    output_req      = output_en;
    output_req_addr = output_addr;
    write_req       = output_we;
    write_req_addr  = output_addr;
    write_req_data  = output_wdata;
    @(posedge clk);
    #1;
    if (write_req) output_mem[write_req_addr[9:0]] = write_req_data;
    if (param_req) param_rdata = param_mem[param_req_addr[1:0]];
    if (bias_req) bias_rdata = bias_mem[bias_req_addr[3:0]];
    if (weight_req) weight_rdata = weight_mem[weight_req_addr[7:0]];
    if (input_req) input_rdata = input_mem[input_req_addr[9:0]];
    if (output_req) output_rdata = output_mem[output_req_addr[9:0]];
  end

  always @(negedge clk) begin : bus_monitor
    if (!rst) begin
      if (quiet && (param_en || bias_en || weight_en || input_en || output_en || output_we))
        report_failure("a memory enable or output_we is high while the engine is idle");
      if (finish) begin
        if (quiet) report_failure("finish pulsed again without a new start");
        quiet = 1'b1;
        finish_count++;
      end
      if (param_en) begin
        verify_in_range("param_addr", param_addr, 3);
        check_addr("param_addr", param_addr, addr_t'(param_idx));
        param_idx++;
      end
      // loads come kernel by kernel, channel innermost
      if (bias_en) begin
        verify_in_range("bias_addr", bias_addr, shape_kernels);
        check_addr("bias_addr", bias_addr, addr_t'(coef_idx / shape_channels));
      end
      if (weight_en) begin
        verify_in_range("weight_addr", weight_addr, shape_kernels * shape_channels);
        check_addr("weight_addr", weight_addr, addr_t'(coef_idx));
      end
      if (bias_en || weight_en) coef_idx++;
      if (input_en)
        verify_in_range("input_addr", input_addr, shape_channels * shape_rows * shape_rows);
      if (output_en)
        verify_in_range("output_addr", output_addr, shape_kernels * shape_rows * shape_rows);
      if (output_we) begin
        verify_in_range("output_addr", output_addr, shape_kernels * shape_rows * shape_rows);
        write_cnt[output_addr[9:0]]++;
      end
    end
  end

  always @(posedge clk) begin : watchdog
    cycle_count++;
    if (cycle_count > cycle_limit)
      report_failure($sformatf("timeout after %0d cycles before all runs finished",
                               cycle_count));
  end

  initial begin : stimulus
    int run;
    seed         = 32'h30f0_8945;
    rst          = 1'b1;
    start        = 1'b0;
    w8           = '0;
    param_rdata  = '0;
    bias_rdata   = '0;
    weight_rdata = '0;
    input_rdata  = '0;
    output_rdata = '0;
    quiet        = 1'b1;
    finish_count = 0;
    cycle_count  = 0;
    param_idx    = 0;
    coef_idx     = 0;
    for (run = 0; run < RUNS; run++) begin
      run_rows[run]     = pick_in_range(3, 8);
      run_channels[run] = pick_in_range(1, 4);
      run_kernels[run]  = pick_in_range(1, 3);
    end
    // second start uses the smallest shape
    run_rows[1]     = 3;
    run_channels[1] = 1;
    cycle_limit = 100;
    for (run = 0; run < RUNS; run++) begin
      cycle_limit += run_kernels[run] * run_channels[run] *
                     (run_rows[run] * run_rows[run] * 12 + 8);
    end
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;
    for (run = 0; run < RUNS; run++) begin
      run_conv(run);
    end
    $display("Simulation PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- conv_top.f
+incdir+hdl
hdl/conv_pkg.sv
hdl/conv_ifs.sv
hdl/conv_sequencer.sv
hdl/conv_coef_fetch.sv
hdl/conv_window_fetch.sv
hdl/conv_mac.sv
hdl/conv_output_writer.sv
hdl/conv_top.sv
testbench/conv_tb.sv

//--- Bender.yml
package:
  name: conv_top

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/conv_pkg.sv
      - hdl/conv_ifs.sv
      - hdl/conv_sequencer.sv
      - hdl/conv_coef_fetch.sv
      - hdl/conv_window_fetch.sv
      - hdl/conv_mac.sv
      - hdl/conv_output_writer.sv
      - hdl/conv_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - testbench/conv_tb.sv
